// ==== ram_access.f ====
src/ram_access_pkg.sv
src/ram_port_mux.sv
src/ram_array_2p.sv
src/ram_capture.sv
src/ram_access_top.sv
test/ram_access_sva.sv
test/ram_access_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the RAM access testbench with Verilator and runs it.
# Exits with status 0 only when the simulation log holds the pass message.

LOG=sim.log
BIN=ram_access_sim

if ! verilator --binary --timing --assert -j 0 \
    -f ram_access.f --top-module ram_access_tb -o "$BIN"; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/"$BIN" +verilator+error+limit+100 > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error status"
  exit 1
fi

cat "$LOG"

if grep -qx "All checks passed" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

// ==== test/ram_access_tb.sv ====
// Testbench for the RAM access wrapper top level.
// Runs reset, functional write and read, write inhibit, bypass, MBIST
// and the return to functional mode against a reference memory model.
// Inputs change on the falling edge, dout is checked on the falling edge.

`timescale 1ns/100ps
`default_nettype none

module ram_access_tb import ram_access_pkg::*; ();

  localparam int N_WORDS = 8;
  localparam int N_PAT   = 4;
  // reset, functional, inhibit, bypass, mbist, return
  localparam int TEST_CYCLES = 7 + N_WORDS * 5 + 5 + 4 + (3 + N_PAT * 5) + 4;
  localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

  logic clk = 1'b0;
  logic mbist_ramaccess_rst_;
  logic [ADDR_W-1:0] wa, ra, mbist_wa_w0, mbist_ra_r0;
  logic [DATA_W-1:0] di, dout;
  logic [PAT_W-1:0]  mbist_di_w0;
  logic we, re, ore, write_inh, scan_ramtms, ary_read_inh;
  logic mbist_en_sync, mbist_we_w0, mbist_ce_r0;

  logic [DATA_W-1:0] model [2**ADDR_W];
  logic [ADDR_W-1:0] addrs [N_WORDS];
  int seed, errors, checks, err_mark, cycles;

  ram_access_top #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) i_dut (.*);

  always #10 clk = ~clk;

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [DATA_W-1:0] replicate_pattern(logic [PAT_W-1:0] pat);
    logic [DATA_W-1:0] word;
    word = '0;
    for (int i = 0; i < DATA_W; i += PAT_W) begin
      word[i +: PAT_W] = pat;
    end
    return word;
  endfunction

  task automatic check_dout(logic [DATA_W-1:0] exp);
    checks++;
    assert (dout === exp) else begin
      $display("Error at %0d ns: dout expected %h, actual %h", $time, exp, dout);
      errors++;
    end
  endtask

  task automatic end_test(string name);
    $display("test %s finished with %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  task automatic write_word(logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] data, logic inh);
    @(negedge clk);
    wa = addr;
    di = data;
    we = 1'b1;
    write_inh = inh;
    @(negedge clk);
    we = 1'b0;
    write_inh = 1'b0;
    if (!inh) model[addr] = data;
  endtask

  // re at edge N, ore at edge N+1
  task automatic read_word(logic [ADDR_W-1:0] addr);
    @(negedge clk);
    ra = addr;
    re = 1'b1;
    @(negedge clk);
    re = 1'b0;
    ore = 1'b1;
    @(negedge clk);
    ore = 1'b0;
    check_dout(model[addr]);
  endtask

  task automatic bypass_word(logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] data, logic scan);
    @(negedge clk);
    wa = addr;
    di = data;
    we = 1'b1;
    ore = 1'b1;
    scan_ramtms = scan;
    ary_read_inh = !scan;
    @(negedge clk);
    {we, ore, scan_ramtms, ary_read_inh} = '0;
    model[addr] = data;
    check_dout(data);
  endtask

  task automatic mbist_write(logic [ADDR_W-1:0] addr, logic [PAT_W-1:0] pat);
    @(negedge clk);
    mbist_wa_w0 = addr;
    mbist_di_w0 = pat;
    mbist_we_w0 = 1'b1;
    @(negedge clk);
    mbist_we_w0 = 1'b0;
    model[addr] = replicate_pattern(pat);
  endtask

  // result reaches dout one edge after the read strobe
  task automatic mbist_read(logic [ADDR_W-1:0] addr);
    @(negedge clk);
    mbist_ra_r0 = addr;
    mbist_ce_r0 = 1'b1;
    @(negedge clk);
    mbist_ce_r0 = 1'b0;
    @(negedge clk);
    check_dout(model[addr]);
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin : stimulus
    logic [31:0] rnd;
    seed = 62;
    {errors, checks, err_mark} = '0;
    mbist_ramaccess_rst_ = 1'b1;
    {wa, ra, mbist_wa_w0, mbist_ra_r0, di, mbist_di_w0} = '0;
    {we, re, ore, write_inh, scan_ramtms, ary_read_inh} = '0;
    {mbist_en_sync, mbist_we_w0, mbist_ce_r0} = '0;
    @(negedge clk);
    mbist_ramaccess_rst_ = 1'b0;
    repeat (4) @(negedge clk);
    mbist_ramaccess_rst_ = 1'b1;
    @(negedge clk);
    check_dout('0);
    end_test("reset");

    for (int i = 0; i < N_WORDS; i++) begin
      rnd = $random(seed);
      addrs[i] = rnd[ADDR_W-1:0];
      rnd = $random(seed);
      write_word(addrs[i], rnd[DATA_W-1:0], 1'b0);
    end
    for (int i = 0; i < N_WORDS; i++) read_word(addrs[i]);
    end_test("functional write and read");

    write_word(addrs[0], ~model[addrs[0]], 1'b1);
    read_word(addrs[0]);
    end_test("write inhibit");

    rnd = $random(seed);
    bypass_word(addrs[1], rnd[DATA_W-1:0], 1'b0);
    rnd = $random(seed);
    bypass_word(addrs[2], rnd[DATA_W-1:0], 1'b1);
    end_test("bypass");

    @(negedge clk);
    mbist_en_sync = 1'b1;
    for (int j = 0; j < N_PAT; j++) begin
      rnd = $random(seed);
      mbist_write(addrs[j], rnd[PAT_W-1:0]);
    end
    for (int j = 0; j < N_PAT; j++) mbist_read(addrs[j]);
    // ore has no effect while MBIST owns the array
    // bypass offers an inverted background, so a wrong load shows on dout
    @(negedge clk);
    mbist_di_w0 = ~model[addrs[N_PAT-1]][PAT_W-1:0];
    ary_read_inh = 1'b1;
    ore = 1'b1;
    @(negedge clk);
    {ore, ary_read_inh} = '0;
    check_dout(model[addrs[N_PAT-1]]);
    end_test("mbist");

    @(negedge clk);
    mbist_en_sync = 1'b0;
    read_word(addrs[0]);
    end_test("return to functional");

    $display("summary: %0d checks, %0d check errors, %0d assertion failures",
             checks, errors, i_dut.i_capture.i_sva.fail_cnt);
    errors += i_dut.i_capture.i_sva.fail_cnt;
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // run limit
  initial begin : watchdog
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: tests did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/ram_access_sva.sv ====
// Concurrent assertions on the output capture block.
// Bound to every ram_capture instance. fail_cnt holds the total of
// assertion failures for the testbench summary.

`timescale 1ns/100ps
`default_nettype none

module ram_access_sva import ram_access_pkg::*; #(
  parameter int DATA_W = 32
) (
  input logic              clk,
  input logic              mbist_ramaccess_rst_,
  input access_mode_e      mode,
  input logic              ore,
  input logic              mbist_ce_r0_1p,
  input logic [DATA_W-1:0] dout
);

  int func_fails  = 0;
  int mbist_fails = 0;
  int rst_fails   = 0;
  int fail_cnt;

  assign fail_cnt = func_fails + mbist_fails + rst_fails;

  // ----------------------------------------
  // hold checks
  // ----------------------------------------
  a_func_hold: assert property (@(posedge clk) disable iff (!mbist_ramaccess_rst_)
    (mode == MODE_FUNC && !ore) |=> $stable(dout))
    else begin
      $error("dout changed without ore in functional mode");
      func_fails++;
    end

  a_mbist_hold: assert property (@(posedge clk) disable iff (!mbist_ramaccess_rst_)
    (mode == MODE_MBIST && !mbist_ce_r0_1p) |=> $stable(dout))
    else begin
      $error("dout changed without the delayed read strobe in MBIST mode");
      mbist_fails++;
    end

  // capture register held clear during reset
  a_rst_clear: assert property (@(posedge clk) !mbist_ramaccess_rst_ |-> dout == '0)
    else begin
      $error("dout is not zero while reset is held");
      rst_fails++;
    end

endmodule

bind ram_capture ram_access_sva #(.DATA_W(DATA_W)) i_sva (
  .clk                  (clk),
  .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
  .mode                 (mode),
  .ore                  (ore),
  .mbist_ce_r0_1p       (mbist_ce_r0_1p),
  .dout                 (dout)
);

`default_nettype wire

// ==== src/ram_access_top.sv ====
// Top level of the 32x32 two-port RAM access wrapper.
// Connects the request selector, the storage array and the output
// capture block. dout carries both functional read data and the MBIST
// read-back. Widths are set here and passed down to every block.

`timescale 1ns/100ps
`default_nettype none

module ram_access_top import ram_access_pkg::*; #(
  parameter int ADDR_W = 5,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              mbist_ramaccess_rst_,
  input  logic [ADDR_W-1:0] wa,
  input  logic [DATA_W-1:0] di,
  input  logic              we,
  input  logic [ADDR_W-1:0] ra,
  input  logic              re,
  input  logic              ore,
  input  logic              write_inh,
  input  logic              scan_ramtms,
  input  logic              ary_read_inh,
  input  logic              mbist_en_sync,
  input  logic [ADDR_W-1:0] mbist_wa_w0,
  input  logic [PAT_W-1:0]  mbist_di_w0,
  input  logic              mbist_we_w0,
  input  logic [ADDR_W-1:0] mbist_ra_r0,
  input  logic              mbist_ce_r0,
  output logic [DATA_W-1:0] dout
);

  access_mode_e      mode;
  ram_wr_req_t       wr_req;
  ram_rd_req_t       rd_req;
  logic [DATA_W-1:0] rd_data;

  // ----------------------------------------
  // request select
  // ----------------------------------------
  ram_port_mux #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) i_port_mux (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .mbist_en_sync        (mbist_en_sync),
    .we                   (we),
    .re                   (re),
    .mbist_we_w0          (mbist_we_w0),
    .mbist_ce_r0          (mbist_ce_r0),
    .write_inh            (write_inh),
    .wa                   (wa),
    .ra                   (ra),
    .mbist_wa_w0          (mbist_wa_w0),
    .mbist_ra_r0          (mbist_ra_r0),
    .di                   (di),
    .mbist_di_w0          (mbist_di_w0),
    .mode                 (mode),
    .wr_req               (wr_req),
    .rd_req               (rd_req)
  );

  // storage
  ram_array_2p #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) i_array (
    .clk     (clk),
    .wr_req  (wr_req),
    .rd_req  (rd_req),
    .rd_data (rd_data)
  );

  // bypass mux and output register
  ram_capture #(
    .DATA_W (DATA_W)
  ) i_capture (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .mode                 (mode),
    .ore                  (ore),
    .mbist_ce_r0          (mbist_ce_r0),
    .scan_ramtms          (scan_ramtms),
    .ary_read_inh         (ary_read_inh),
    .wr_req               (wr_req),
    .rd_data              (rd_data),
    .dout                 (dout)
  );

endmodule

`default_nettype wire

// ==== src/ram_capture.sv ====
// Output side of the RAM wrapper.
// Picks the write data when the array is bypassed, else the array read
// data, and loads it into the capture register that drives dout. In
// functional mode ore loads the register; in MBIST mode mbist_ce_r0
// loads it one cycle later through a delay flop.

`timescale 1ns/100ps
`default_nettype none

module ram_capture import ram_access_pkg::*; #(
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              mbist_ramaccess_rst_,
  input  access_mode_e      mode,
  input  logic              ore,
  input  logic              mbist_ce_r0,
  input  logic              scan_ramtms,
  input  logic              ary_read_inh,
  input  ram_wr_req_t       wr_req,
  input  logic [DATA_W-1:0] rd_data,
  output logic [DATA_W-1:0] dout
);

  logic              bypass;
  logic              mbist_ce_r0_1p;
  logic              capture;
  logic [DATA_W-1:0] cap_data;

  // array bypass for test, write data goes straight to the capture reg
  assign bypass   = scan_ramtms | ary_read_inh;
  assign cap_data = bypass ? wr_req.data : rd_data;

  // mbist read strobe lines up with the registered array output
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      mbist_ce_r0_1p <= 1'b0;
    end else begin
      mbist_ce_r0_1p <= mbist_ce_r0;
    end
  end

  // ore is ignored while mbist owns the array
  assign capture = (mode == MODE_MBIST) ? mbist_ce_r0_1p : ore;

  // ----------------------------------------
  // capture register
  // ----------------------------------------
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      dout <= '0;
    end else if (capture) begin
      dout <= cap_data;
    end
  end

endmodule

`default_nettype wire

// ==== src/ram_array_2p.sv ====
// Two-port storage array, one write port and one read port.
// Writes land at the clock edge where wr_req.en is high. The read data
// register loads on rd_req.en and holds otherwise. A read and a write to
// the same address at one edge return the old word.

`timescale 1ns/100ps
`default_nettype none

module ram_array_2p import ram_access_pkg::*; #(
  parameter int ADDR_W = 5,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  ram_wr_req_t       wr_req,
  input  ram_rd_req_t       rd_req,
  output logic [DATA_W-1:0] rd_data
);

  localparam int DEPTH = 2 ** ADDR_W;

  logic [DATA_W-1:0] mem [DEPTH];

  // ----------------------------------------
  // write port
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (wr_req.en) begin
      mem[wr_req.addr] <= wr_req.data;
    end
  end

  // ----------------------------------------
  // read port
  // ----------------------------------------
  // nonblocking update of mem gives read-first on an address collision
  always_ff @(posedge clk) begin
    if (rd_req.en) begin
      rd_data <= mem[rd_req.addr];
    end
  end

endmodule

`default_nettype wire

// ==== src/ram_port_mux.sv ====
// Request selector in front of the storage array.
// Registers the MBIST enable as the access mode, then drives one write
// request and one read request from either the functional port or the
// MBIST port. write_inh blocks every array write, in both modes.

`timescale 1ns/100ps
`default_nettype none

module ram_port_mux import ram_access_pkg::*; #(
  parameter int ADDR_W = 5,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              mbist_ramaccess_rst_,
  input  logic              mbist_en_sync,
  input  logic              we,
  input  logic              re,
  input  logic              mbist_we_w0,
  input  logic              mbist_ce_r0,
  input  logic              write_inh,
  input  logic [ADDR_W-1:0] wa,
  input  logic [ADDR_W-1:0] ra,
  input  logic [ADDR_W-1:0] mbist_wa_w0,
  input  logic [ADDR_W-1:0] mbist_ra_r0,
  input  logic [DATA_W-1:0] di,
  input  logic [PAT_W-1:0]  mbist_di_w0,
  output access_mode_e      mode,
  output ram_wr_req_t       wr_req,
  output ram_rd_req_t       rd_req
);

  // background must tile the word exactly
  if (DATA_W % PAT_W != 0) begin : g_pat_check
    $error("DATA_W must be a multiple of PAT_W");
  end

  logic [DATA_W-1:0] mbist_data;

  // ----------------------------------------
  // mode state
  // ----------------------------------------
  // one flop on mbist_en_sync, mode follows at the next edge
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      mode <= MODE_FUNC;
    end else begin
      mode <= mbist_en_sync ? MODE_MBIST : MODE_FUNC;
    end
  end

  // 2-bit background repeated across the full word
  assign mbist_data = {(DATA_W / PAT_W){mbist_di_w0}};

  // ----------------------------------------
  // request select
  // ----------------------------------------
  always_comb begin
    case (mode)
      MODE_MBIST: begin
        wr_req.en   = mbist_we_w0 & ~write_inh;
        wr_req.addr = mbist_wa_w0;
        wr_req.data = mbist_data;
        rd_req.en   = mbist_ce_r0;
        rd_req.addr = mbist_ra_r0;
      end
      default: begin
        wr_req.en   = we & ~write_inh;
        wr_req.addr = wa;
        wr_req.data = di;
        rd_req.en   = re;
        rd_req.addr = ra;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/ram_access_pkg.sv ====
// Shared widths and types for the 32x32 two-port RAM access wrapper.
// Every RTL file and the testbench import this package with a wildcard
// import in the module header. The top level sets its own ADDR_W and
// DATA_W parameters and passes them down to the submodules.

`default_nettype none

package ram_access_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  parameter int ADDR_W = 5;
  parameter int DATA_W = 32;
  // mbist background, replicated across the word, so DATA_W % PAT_W == 0
  parameter int PAT_W  = 2;

  // ----------------------------------------
  // types
  // ----------------------------------------
  // source of the requests that reach the array
  typedef enum logic {
    MODE_FUNC  = 1'b0,
    MODE_MBIST = 1'b1
  } access_mode_e;

  typedef struct packed {
    logic              en;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } ram_wr_req_t;

  typedef struct packed {
    logic              en;
    logic [ADDR_W-1:0] addr;
  } ram_rd_req_t;

endpackage

`default_nettype wire
